// ==== design/domain_pkg.sv ====
/*
 * Shared types and sizes for the domain manager.
 * Modules pull these in with a wildcard import in their header.
 */

package domain_pkg;

	////////////////////////////////////////////////////////////
	// Table geometry
	////////////////////////////////////////////////////////////

	localparam int NUM_ENTRY = 8;					// Domains tracked at once
	localparam int ENTRY_W   = $clog2(NUM_ENTRY);	// Bits of a table index

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	// Domain base address as issued by the store and load streams
	typedef logic [31:0] address_t;

	// Bit 0 and 1 are the local requesters, bit 2 the external one
	typedef logic [2:0] grant_vec_t;

	// Arbiter grant number where value 3 addresses nobody
	typedef logic [1:0] grant_no_t;

	typedef logic [ENTRY_W-1:0] entry_idx_t;		// Table entry index

endpackage

// ==== design/grant_port.sv ====
/*
 * One grant port of the domain manager, used once for stores and once for loads.
 * Turns rising grant lines into a single event while the pipeline runs, and
 * routes the table's readiness level to the requester the arbiter granted.
 */

`timescale 1ns/1ps

module grant_port
	import domain_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       stall,			// Pipeline stall, blocks events
	input  grant_vec_t grant,			// Raw grant lines from the arbiter
	input  logic       grant_vld,		// Grant number is meaningful
	input  grant_no_t  grant_no,		// Which requester holds the grant
	input  logic       ready_level,		// Readiness computed by the table
	output logic       grant_event,		// Any rising grant edge, not stalled
	output grant_vec_t ready			// One-hot readiness per requester
);

	////////////////////////////////////////////////////////////
	// Edge detection
	////////////////////////////////////////////////////////////

	grant_vec_t grant_q;				// Grant lines one cycle ago
	grant_vec_t grant_rise;				// Lines that went high this cycle

	// Keeps tracking during stall, so an edge seen while stalled is gone
	always_ff @(posedge clock) begin
		if (reset) begin
			grant_q <= '0;
		end else begin
			grant_q <= grant;
		end
	end

	assign grant_rise  = grant & ~grant_q;
	assign grant_event = (|grant_rise) & ~stall;

	////////////////////////////////////////////////////////////
	// Ready routing
	////////////////////////////////////////////////////////////

	// Grant number 3 matches no bit, so ready stays zero for it
	always_comb begin
		ready = '0;
		for (int k = 0; k < $bits(grant_vec_t); k++) begin
			ready[k] = grant_vld & (grant_no == grant_no_t'(k)) & ready_level;
		end
	end

endmodule

// ==== design/domain_table.sv ====
/*
 * Domain table of the memory front end.
 * Holds base addresses with valid and stored flags, searches both the store
 * and load base against every entry, and applies allocation, stored marking
 * and release on the events coming from the two grant ports.
 */

`timescale 1ns/1ps

module domain_table
	import domain_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     st_event,			// Store grant edge
	input  logic     ld_event,			// Load grant edge
	input  logic     st_end,			// Store stream finished its domain
	input  logic     ld_end,			// Final load of the domain
	input  address_t st_base,
	input  address_t ld_base,
	output logic     st_ready_level,	// Store may go ahead
	output logic     ld_ready_level,	// Load may go ahead
	output logic     set_config_st,		// Store edge hit a known domain
	output logic     set_config_ld		// Load edge hit a known domain
);

	////////////////////////////////////////////////////////////
	// Table state
	////////////////////////////////////////////////////////////

	address_t             entry_addr [NUM_ENTRY];	// Base address per entry
	logic [NUM_ENTRY-1:0] entry_valid;
	logic [NUM_ENTRY-1:0] entry_stored;				// Written, ready for loads
	entry_idx_t           wr_ptr;					// Next entry to allocate

	logic [NUM_ENTRY-1:0] st_hit_vec;
	logic [NUM_ENTRY-1:0] ld_hit_vec;
	logic                 st_hit;
	logic                 ld_hit;
	entry_idx_t           st_idx;
	entry_idx_t           ld_idx;

	logic                 do_alloc;		// New domain from the store side
	logic                 do_mark;		// Existing domain now stored
	logic                 do_release;	// Domain freed after last load

	// Lowest set bit wins, index 0 if none is set
	function automatic entry_idx_t lowest_hit(input logic [NUM_ENTRY-1:0] hits);
		entry_idx_t idx;
		idx = '0;
		for (int i = NUM_ENTRY - 1; i >= 0; i--) begin
			if (hits[i]) begin
				idx = entry_idx_t'(i);
			end
		end
		return idx;
	endfunction

	////////////////////////////////////////////////////////////
	// Parallel search
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < NUM_ENTRY; i++) begin
			st_hit_vec[i] = entry_valid[i] & (entry_addr[i] == st_base);
			ld_hit_vec[i] = entry_valid[i] & (entry_addr[i] == ld_base);
		end
	end

	assign st_hit = |st_hit_vec;
	assign ld_hit = |ld_hit_vec;
	assign st_idx = lowest_hit(st_hit_vec);
	assign ld_idx = lowest_hit(ld_hit_vec);

	// A store may proceed on a new domain or one not yet stored
	assign st_ready_level = ~st_hit | ~entry_stored[st_idx];
	assign ld_ready_level = ld_hit & entry_stored[ld_idx];

	assign set_config_st = st_event & st_hit;
	assign set_config_ld = ld_event & ld_hit;

	assign do_alloc   = st_event & ~st_hit & st_end;
	assign do_mark    = set_config_st & st_end;
	assign do_release = set_config_ld & ld_end;

	////////////////////////////////////////////////////////////
	// Flag and address update
	////////////////////////////////////////////////////////////

	// On the same entry a release beats a mark, and an allocation beats both
	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid  <= '0;
			entry_stored <= '0;
		end else begin
			if (do_mark) begin
				entry_stored[st_idx] <= 1'b1;
			end
			if (do_release) begin
				entry_valid[ld_idx]  <= 1'b0;
				entry_stored[ld_idx] <= 1'b0;
			end
			if (do_alloc) begin
				entry_valid[wr_ptr]  <= 1'b1;
				entry_stored[wr_ptr] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_alloc) begin
			entry_addr[wr_ptr] <= st_base;	// Oldest slot gets overwritten
		end
	end

	// Round-robin allocation pointer
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (do_alloc) begin
			if (wr_ptr == entry_idx_t'(NUM_ENTRY - 1)) begin
				wr_ptr <= '0;
			end else begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

endmodule

// ==== design/domain_man.sv ====
/*
 * Top of the domain manager.
 * Joins the store grant port, the load grant port and the shared domain
 * table. All outputs are combinational on the inputs of the same cycle.
 */

`timescale 1ns/1ps

module domain_man
	import domain_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       stall,

	// Store side
	input  grant_vec_t st_grant,
	input  logic       st_grant_vld,
	input  grant_no_t  st_grant_no,
	input  address_t   st_base,
	input  logic       st_end,

	// Load side
	input  grant_vec_t ld_grant,
	input  logic       ld_grant_vld,
	input  grant_no_t  ld_grant_no,
	input  address_t   ld_base,
	input  logic       ld_end,

	output grant_vec_t st_ready,
	output grant_vec_t ld_ready,
	output logic       set_config_st,
	output logic       set_config_ld
);

	logic st_event;
	logic ld_event;
	logic st_ready_level;
	logic ld_ready_level;

	////////////////////////////////////////////////////////////
	// Grant ports
	////////////////////////////////////////////////////////////

	grant_port st_port (
		.clock       (clock),
		.reset       (reset),
		.stall       (stall),
		.grant       (st_grant),
		.grant_vld   (st_grant_vld),
		.grant_no    (st_grant_no),
		.ready_level (st_ready_level),
		.grant_event (st_event),
		.ready       (st_ready)
	);

	grant_port ld_port (
		.clock       (clock),
		.reset       (reset),
		.stall       (stall),
		.grant       (ld_grant),
		.grant_vld   (ld_grant_vld),
		.grant_no    (ld_grant_no),
		.ready_level (ld_ready_level),
		.grant_event (ld_event),
		.ready       (ld_ready)
	);

	////////////////////////////////////////////////////////////
	// Domain table
	////////////////////////////////////////////////////////////

	domain_table table_inst (
		.clock          (clock),
		.reset          (reset),
		.st_event       (st_event),
		.ld_event       (ld_event),
		.st_end         (st_end),
		.ld_end         (ld_end),
		.st_base        (st_base),
		.ld_base        (ld_base),
		.st_ready_level (st_ready_level),
		.ld_ready_level (ld_ready_level),
		.set_config_st  (set_config_st),
		.set_config_ld  (set_config_ld)
	);

endmodule

// ==== test/domain_man_props.sv ====
/*
 * Concurrent checks on the outputs of the domain manager.
 * Bound into domain_man; the number of failed assertions is kept in failures.
 */

`timescale 1ns/1ps

module domain_man_props
	import domain_pkg::*;
(
	input logic       clock,
	input logic       reset,
	input logic       stall,
	input grant_vec_t ld_grant,
	input grant_vec_t st_ready,
	input grant_vec_t ld_ready,
	input logic       set_config_st,
	input logic       set_config_ld
);

	int failures = 0;					// Failed assertions so far

	cfg_st_not_stalled: assert property (@(posedge clock) disable iff (reset)
		set_config_st |-> !stall)
	else begin
		failures++;
		$error("set_config_st fired while stall was high");
	end

	st_ready_onehot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(st_ready))
	else begin
		failures++;
		$error("st_ready has more than one bit set");
	end

	ld_ready_onehot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(ld_ready))
	else begin
		failures++;
		$error("ld_ready has more than one bit set");
	end

	cfg_ld_needs_grant: assert property (@(posedge clock) disable iff (reset)
		set_config_ld |-> (|ld_grant))
	else begin
		failures++;
		$error("set_config_ld fired with no ld_grant line high");
	end

endmodule

bind domain_man domain_man_props props_inst (
	.clock         (clock),
	.reset         (reset),
	.stall         (stall),
	.ld_grant      (ld_grant),
	.st_ready      (st_ready),
	.ld_ready      (ld_ready),
	.set_config_st (set_config_st),
	.set_config_ld (set_config_ld)
);

// ==== test/domain_man_tb.sv ====
/*
 * Testbench for the domain manager.
 * Drives random grants, bases, end strobes and stall from an LFSR, keeps its
 * own model of the domain table and checks ready and set_config every cycle.
 */

`timescale 1ns/1ps

module domain_man_tb
	import domain_pkg::*;
();

	localparam int          NUM_CYCLES     = 3000;
	localparam int          TIMEOUT_CYCLES = 4000;
	localparam logic [31:0] LFSR_SEED      = 32'h6f54_2eb1;
	localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;	// x^32 + x^22 + x^2 + x + 1

	logic       clock = 1'b0;
	logic       reset = 1'b1;
	logic       stall;
	grant_vec_t st_grant;
	logic       st_grant_vld;
	grant_no_t  st_grant_no;
	address_t   st_base;
	logic       st_end;
	grant_vec_t ld_grant;
	logic       ld_grant_vld;
	grant_no_t  ld_grant_no;
	address_t   ld_base;
	logic       ld_end;
	grant_vec_t st_ready;
	grant_vec_t ld_ready;
	logic       set_config_st;
	logic       set_config_ld;

	logic [31:0] lfsr;
	logic        run_done    = 1'b0;
	int          error_count = 0;
	int          cycle_count = 0;

	// Reference copy of the table
	address_t             m_addr [NUM_ENTRY];
	logic [NUM_ENTRY-1:0] m_valid;
	logic [NUM_ENTRY-1:0] m_stored;
	entry_idx_t           m_wr_ptr;
	grant_vec_t           m_prev_st;
	grant_vec_t           m_prev_ld;

	domain_man domain_man_inst (.*);

	always #5 clock = ~clock;			// 10 ns period

	////////////////////////////////////////////////////////////
	// Random source
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};	// One step per bit
		end
	endtask

	function automatic address_t pick_base(input logic [1:0] sel);
		case (sel)
			2'd0:    return 32'h0000_1000;
			2'd1:    return 32'h0004_2000;
			2'd2:    return 32'h0010_8000;
			default: return 32'h8000_0040;
		endcase
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		draw_bits(3, r);
		stall <= (r[2:0] == 3'b111);		// About 1 in 8
		draw_bits(3, r);
		st_grant <= r[2:0];
		draw_bits(1, r);
		st_grant_vld <= r[0];
		draw_bits(2, r);
		st_grant_no <= r[1:0];
		draw_bits(2, r);
		st_base <= pick_base(r[1:0]);
		draw_bits(1, r);
		st_end <= r[0];
		draw_bits(3, r);
		ld_grant <= r[2:0];
		draw_bits(1, r);
		ld_grant_vld <= r[0];
		draw_bits(2, r);
		ld_grant_no <= r[1:0];
		draw_bits(2, r);
		ld_base <= pick_base(r[1:0]);
		draw_bits(2, r);
		ld_end <= (r[1:0] == 2'b00);		// Final load is rarer
	endtask

	////////////////////////////////////////////////////////////
	// Model
	////////////////////////////////////////////////////////////

	task automatic find_hit(input address_t base, output logic hit, output entry_idx_t idx);
		hit = 1'b0;
		idx = '0;
		for (int i = 0; i < NUM_ENTRY; i++) begin
			if (!hit && m_valid[i] && (m_addr[i] == base)) begin
				hit = 1'b1;
				idx = entry_idx_t'(i);
			end
		end
	endtask

	function automatic grant_vec_t route_ready(input logic vld, input grant_no_t no,
			input logic level);
		grant_vec_t r;
		r = '0;
		if (vld && level && (no != 2'd3)) begin
			r[no] = 1'b1;
		end
		return r;
	endfunction

	// Outputs are stable at the falling edge and state moves at the next rising one
	always @(negedge clock) begin : model_check
		grant_vec_t exp_st_ready;
		grant_vec_t exp_ld_ready;
		logic       st_ev;
		logic       ld_ev;
		logic       st_hit;
		logic       ld_hit;
		entry_idx_t st_idx;
		entry_idx_t ld_idx;
		logic       exp_cfg_st;
		logic       exp_cfg_ld;
		if (reset) begin
			m_valid   = '0;
			m_stored  = '0;
			m_wr_ptr  = '0;
			m_prev_st = '0;
			m_prev_ld = '0;
			for (int i = 0; i < NUM_ENTRY; i++) begin
				m_addr[i] = '0;
			end
		end else begin
			cycle_count++;
			st_ev = (|(st_grant & ~m_prev_st)) && !stall;
			ld_ev = (|(ld_grant & ~m_prev_ld)) && !stall;
			find_hit(st_base, st_hit, st_idx);
			find_hit(ld_base, ld_hit, ld_idx);
			exp_st_ready = route_ready(st_grant_vld, st_grant_no, !st_hit || !m_stored[st_idx]);
			exp_ld_ready = route_ready(ld_grant_vld, ld_grant_no, ld_hit && m_stored[ld_idx]);
			exp_cfg_st   = st_ev && st_hit;
			exp_cfg_ld   = ld_ev && ld_hit;

			if (st_ready !== exp_st_ready) begin
				error_count++;
				$display("CHECK FAILED st_ready: expected %h, got %h (cycle %0d)",
					exp_st_ready, st_ready, cycle_count);
			end
			if (ld_ready !== exp_ld_ready) begin
				error_count++;
				$display("CHECK FAILED ld_ready: expected %h, got %h (cycle %0d)",
					exp_ld_ready, ld_ready, cycle_count);
			end
			if (set_config_st !== exp_cfg_st) begin
				error_count++;
				$display("CHECK FAILED set_config_st: expected %h, got %h (cycle %0d)",
					exp_cfg_st, set_config_st, cycle_count);
			end
			if (set_config_ld !== exp_cfg_ld) begin
				error_count++;
				$display("CHECK FAILED set_config_ld: expected %h, got %h (cycle %0d)",
					exp_cfg_ld, set_config_ld, cycle_count);
			end

			// Mark first, release second, allocation last
			if (exp_cfg_st && st_end) begin
				m_stored[st_idx] = 1'b1;
			end
			if (exp_cfg_ld && ld_end) begin
				m_valid[ld_idx]  = 1'b0;
				m_stored[ld_idx] = 1'b0;
			end
			if (st_ev && !st_hit && st_end) begin
				m_addr[m_wr_ptr]   = st_base;
				m_valid[m_wr_ptr]  = 1'b1;
				m_stored[m_wr_ptr] = 1'b0;
				if (m_wr_ptr == entry_idx_t'(NUM_ENTRY - 1)) begin
					m_wr_ptr = '0;
				end else begin
					m_wr_ptr = m_wr_ptr + 1'b1;
				end
			end
			m_prev_st = st_grant;
			m_prev_ld = ld_grant;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus and verdict
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		lfsr         = LFSR_SEED;
		stall        = 1'b0;
		st_grant     = '0;
		st_grant_vld = 1'b0;
		st_grant_no  = '0;
		st_base      = '0;
		st_end       = 1'b0;
		ld_grant     = '0;
		ld_grant_vld = 1'b0;
		ld_grant_no  = '0;
		ld_base      = '0;
		ld_end       = 1'b0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		for (int n = 0; n < NUM_CYCLES; n++) begin
			@(posedge clock);
			drive_random();
		end
		@(posedge clock);
		run_done <= 1'b1;
	end

	initial begin : verdict
		int waited;
		int assert_fails;
		waited = 0;
		while (!run_done && (waited < TIMEOUT_CYCLES)) begin
			@(posedge clock);
			waited++;
		end
		#1;									// Assertions of this edge have finished
		assert_fails = domain_man_inst.props_inst.failures;
		if (!run_done) begin
			$display("Timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
		end else begin
			$display("Closing: %0d check errors, %0d assertion failures, %0d cycles checked",
				error_count, assert_fails, cycle_count);
			if ((error_count == 0) && (assert_fails == 0)) begin
				$display("Verification passed");
			end else begin
				$display("Verification failed");
			end
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
design/domain_pkg.sv
design/grant_port.sv
design/domain_table.sv
design/domain_man.sv
test/domain_man_props.sv
test/domain_man_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the domain manager simulation with Verilator and run it

verilator --binary --timing --assert --top-module domain_man_tb \
	-f verilog.f -o domain_man_sim || exit 1

output=$(./obj_dir/domain_man_sim +verilator+error+limit+1000)
echo "$output"
echo "$output" | grep -qx "Verification passed" && echo "PASS" || { echo "FAIL"; exit 1; }
